//--- Makefile
# Verilator build and run of the ADC post-processing testbench
TOP = tb_adc_processing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- build.f
verilog/adc_proc_pkg.sv
verilog/adc_control_regs.sv
verilog/adc_calibration.sv
verilog/threshold_comparator.sv
verilog/sample_decimator.sv
verilog/adc_processing.sv
testbench/tb_adc_processing.sv

//--- testbench/tb_adc_processing.sv
/*
 * Directed testbench of the ADC post-processing block.
 * Drives the sample stream and the register bus on the falling clock edge and
 * checks registers, calibration, decimation, both comparators and the fault.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_processing;

    import adc_proc_pkg::*;

    // Several times the length of all tests together
    localparam int MAX_CYCLES  = 4000;
    localparam int FAULT_DELAY = 5;

    logic      clock;
    logic      arst_n;
    logic      sample_valid;
    channel_t  sample_channel;
    sample_t   sample_data;
    logic      reg_write;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      fast_valid;
    channel_t  fast_channel;
    sample_t   fast_data;
    logic      filtered_valid;
    channel_t  filtered_channel;
    sample_t   filtered_data;
    logic      fast_trip_high;
    logic      fast_trip_low;
    logic      slow_trip_high;
    logic      slow_trip_low;
    logic      fault;

    int          cycle_count;
    int          error_count;
    logic [31:0] rng_state;
    // Offsets the DUT holds per channel, kept for the calibration model
    sample_t     cal_off [4];
    // Fast trip levels expected after the last comparator step
    logic        exp_fast_high;
    logic        exp_fast_low;

    adc_processing #(
        .N_CHANNELS(4),
        .STICKY_FAULT(1)
    ) i_adc_processing (
        .clock(clock),
        .arst_n(arst_n),
        .sample_valid(sample_valid),
        .sample_channel(sample_channel),
        .sample_data(sample_data),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .fast_valid(fast_valid),
        .fast_channel(fast_channel),
        .fast_data(fast_data),
        .filtered_valid(filtered_valid),
        .filtered_channel(filtered_channel),
        .filtered_data(filtered_data),
        .fast_trip_high(fast_trip_high),
        .fast_trip_low(fast_trip_low),
        .slow_trip_high(slow_trip_high),
        .slow_trip_low(slow_trip_low),
        .fault(fault)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Errors found");
            $fatal(1, "Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    // 32-bit xorshift generator for sample data and channels
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Offset added with saturation to the 16-bit range, then shifted keeping the sign
    function automatic sample_t calibrated(input sample_t data, input sample_t offset,
                                           input int shift);
        int      sum;
        sample_t clamped;
        sum = int'(data) + int'(offset);
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        clamped = sample_t'(sum);
        return clamped >>> shift;
    endfunction

    // Control word built field by field from the register layout
    function automatic reg_data_t control_word(input logic [1:0] latch, input logic [1:0] clear,
                                               input int shift, input int delay,
                                               input logic clear_flt, input logic no_fault,
                                               input int decim);
        return {8'(decim), 6'd0, no_fault, clear_flt, 8'(delay), 3'(shift), clear, latch, 1'b0};
    endfunction

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(negedge clock);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr, input reg_data_t expected);
        @(negedge clock);
        reg_addr = addr;
        #1;
        check_value($sformatf("read of register 0x%0h", addr), reg_rdata, expected);
    endtask

    // The caller stands on a falling edge; returns one cycle later with valid low again
    task automatic send_sample(input channel_t ch, input sample_t data);
        sample_valid   = 1'b1;
        sample_channel = ch;
        sample_data    = data;
        @(negedge clock);
        sample_valid = 1'b0;
    endtask

    // One comparator gets the window, the other a window that never trips
    task automatic set_window(input logic slow_side, input sample_t lf, input sample_t lr,
                              input sample_t hf, input sample_t hr);
        write_reg(ADDR_CMP_LOW_F, slow_side ? {lf, 16'h8000} : {16'h8000, lf});
        write_reg(ADDR_CMP_LOW_R, slow_side ? {lr, 16'h8000} : {16'h8000, lr});
        write_reg(ADDR_CMP_HIGH_F, slow_side ? {hf, 16'h7FFF} : {16'h7FFF, hf});
        write_reg(ADDR_CMP_HIGH_R, slow_side ? {hr, 16'h7FFF} : {16'h7FFF, hr});
    endtask

    task automatic test_registers();
        reg_addr_t   thr_addr [4];
        logic [31:0] word;
        thr_addr = '{ADDR_CMP_LOW_F, ADDR_CMP_LOW_R, ADDR_CMP_HIGH_F, ADDR_CMP_HIGH_R};
        for (int i = 0; i < 4; i++) begin
            read_check(thr_addr[i], '0);
        end
        read_check(ADDR_CAL_COEFF, '0);
        read_check(ADDR_CONTROL, '0);
        check_value("outputs after reset", {fast_valid, filtered_valid, fast_trip_high,
                    fast_trip_low, slow_trip_high, slow_trip_low, fault}, '0);
        for (int i = 0; i < 4; i++) begin
            word = next_random();
            write_reg(thr_addr[i], word);
            read_check(thr_addr[i], word);
        end
        // Coefficient keeps only the channel index and the offset
        write_reg(ADDR_CAL_COEFF, 32'h1234_FFFE);
        read_check(ADDR_CAL_COEFF, 32'h1234_0002);
        // Clear bits are strobes and read back as zero
        write_reg(ADDR_CONTROL, control_word(2'b11, 2'b11, 7, 8'h3C, 1'b1, 1'b1, 5));
        read_check(ADDR_CONTROL, control_word(2'b11, 2'b00, 7, 8'h3C, 1'b0, 1'b1, 5));
        write_reg(5'h18, 32'hFFFF_FFFF);
        read_check(5'h18, '0);
        write_reg(ADDR_CONTROL, '0);
    endtask

    task automatic test_calibration();
        logic [31:0] r;
        channel_t    ch;
        sample_t     data;
        // Large offsets of both signs push many random samples into saturation
        cal_off[0] = 16'sh7000;
        cal_off[1] = 16'sh9000;
        cal_off[2] = 16'sh0123;
        cal_off[3] = 16'shFFC0;
        for (int i = 0; i < 4; i++) begin
            write_reg(ADDR_CAL_COEFF, {cal_off[i], 14'd0, 2'(i)});
        end
        for (int shift = 0; shift < 8; shift++) begin
            write_reg(ADDR_CONTROL, control_word(2'b00, 2'b00, shift, 0, 1'b0, 1'b0, 1));
            for (int n = 0; n < 16; n++) begin
                r    = next_random();
                ch   = r[1:0];
                data = r[31:16];
                @(negedge clock);
                check_value("fast_valid before the sample", fast_valid, 1'b0);
                send_sample(ch, data);
                check_value("fast_valid", fast_valid, 1'b1);
                check_value("fast_channel", fast_channel, ch);
                check_value("fast_data", fast_data, calibrated(data, cal_off[ch], shift));
            end
        end
        for (int i = 0; i < 4; i++) begin
            cal_off[i] = '0;
            write_reg(ADDR_CAL_COEFF, {16'd0, 14'd0, 2'(i)});
        end
    endtask

    task automatic test_decimation();
        int       ratios [3];
        int       ratio;
        int       count [4];
        channel_t chans [24];
        sample_t  datas [24];
        logic     fwd [24];
        ratios = '{1, 3, 0};
        // Each run sends six samples per channel, so every counter ends at zero
        for (int c = 0; c < 4; c++) begin
            count[c] = 0;
        end
        for (int t = 0; t < 3; t++) begin
            write_reg(ADDR_CONTROL, control_word(2'b00, 2'b00, 0, 0, 1'b0, 1'b0, ratios[t]));
            ratio = (ratios[t] == 0) ? 1 : ratios[t];
            for (int i = 0; i < 24; i++) begin
                chans[i]         = 2'(i % 4);
                datas[i]         = 16'(next_random());
                fwd[i]           = (count[i % 4] == 0);
                count[i % 4] = (count[i % 4] + 1) % ratio;
            end
            for (int k = 0; k < 26; k++) begin
                @(negedge clock);
                if (k >= 1 && k <= 24) begin
                    check_value("fast_valid in burst", fast_valid, 1'b1);
                    check_value("fast_channel in burst", fast_channel, chans[k - 1]);
                    check_value("fast_data in burst", fast_data,
                                calibrated(datas[k - 1], cal_off[chans[k - 1]], 0));
                end
                if (k >= 2) begin
                    check_value("filtered_valid", filtered_valid, fwd[k - 2]);
                    if (fwd[k - 2]) begin
                        check_value("filtered_channel", filtered_channel, chans[k - 2]);
                        check_value("filtered_data", filtered_data,
                                    calibrated(datas[k - 2], cal_off[chans[k - 2]], 0));
                    end
                end
                if (k < 24) begin
                    sample_valid   = 1'b1;
                    sample_channel = chans[k];
                    sample_data    = datas[k];
                end else begin
                    sample_valid = 1'b0;
                end
            end
        end
    endtask

    // Fast trips keep their value one cycle after the input and take the new one after two
    task automatic fast_step(input channel_t ch, input sample_t data,
                             input logic exp_high, input logic exp_low);
        @(negedge clock);
        send_sample(ch, data);
        check_value("fast_trip_high one cycle after input", fast_trip_high, exp_fast_high);
        check_value("fast_trip_low one cycle after input", fast_trip_low, exp_fast_low);
        @(negedge clock);
        check_value("fast_trip_high", fast_trip_high, exp_high);
        check_value("fast_trip_low", fast_trip_low, exp_low);
        exp_fast_high = exp_high;
        exp_fast_low  = exp_low;
    endtask

    task automatic test_fast_comparator();
        set_window(1'b0, -16'sd1000, -16'sd900, 16'sd900, 16'sd1000);
        write_reg(ADDR_CONTROL, control_word(2'b00, 2'b11, 0, 0, 1'b0, 1'b0, 1));
        @(negedge clock);
        check_value("trips after clear", {fast_trip_high, fast_trip_low,
                    slow_trip_high, slow_trip_low}, '0);
        exp_fast_high = 1'b0;
        exp_fast_low  = 1'b0;
        // Normal mode, values between the two thresholds keep the state
        fast_step(2'd1, 16'sd1100, 1'b1, 1'b0);
        fast_step(2'd1, 16'sd950, 1'b1, 1'b0);
        fast_step(2'd1, 16'sd850, 1'b0, 1'b0);
        fast_step(2'd1, 16'sd950, 1'b0, 1'b0);
        fast_step(2'd1, -16'sd1100, 1'b0, 1'b1);
        fast_step(2'd1, -16'sd950, 1'b0, 1'b1);
        fast_step(2'd1, -16'sd850, 1'b0, 1'b0);
        // Latching mode keeps both trips until the clear strobe
        write_reg(ADDR_CONTROL, control_word(2'b01, 2'b00, 0, 0, 1'b0, 1'b0, 1));
        fast_step(2'd2, 16'sd1100, 1'b1, 1'b0);
        fast_step(2'd2, 16'sd0, 1'b1, 1'b0);
        fast_step(2'd2, -16'sd1100, 1'b1, 1'b1);
        fast_step(2'd2, 16'sd0, 1'b1, 1'b1);
        write_reg(ADDR_CONTROL, control_word(2'b01, 2'b01, 0, 0, 1'b0, 1'b0, 1));
        @(negedge clock);
        check_value("fast trips after clear_latch", {fast_trip_high, fast_trip_low}, '0);
        write_reg(ADDR_CONTROL, control_word(2'b00, 2'b00, 0, 0, 1'b0, 1'b0, 1));
    endtask

    task automatic test_slow_fault();
        int wait_cycles;
        set_window(1'b1, -16'sd2000, -16'sd1900, 16'sd1900, 16'sd2000);
        write_reg(ADDR_CONTROL, control_word(2'b00, 2'b11, 0, FAULT_DELAY, 1'b0, 1'b0, 1));
        write_reg(ADDR_CONTROL, control_word(2'b00, 2'b00, 0, FAULT_DELAY, 1'b1, 1'b0, 1));
        @(negedge clock);
        check_value("fault before the test", fault, 1'b0);
        check_value("slow trips before the test", {slow_trip_high, slow_trip_low}, '0);
        // Sustained excursion, the slow trip follows the input after three cycles
        send_sample(2'd0, 16'sd2500);
        check_value("slow_trip_high after one cycle", slow_trip_high, 1'b0);
        @(negedge clock);
        check_value("slow_trip_high after two cycles", slow_trip_high, 1'b0);
        @(negedge clock);
        check_value("slow_trip_high after three cycles", slow_trip_high, 1'b1);
        wait_cycles = 0;
        while (!fault && wait_cycles < 50) begin
            @(negedge clock);
            wait_cycles++;
        end
        check_value("cycles from slow trip to fault", wait_cycles, FAULT_DELAY + 1);
        // Sticky fault outlives the trip
        send_sample(2'd0, 16'sd0);
        repeat (10) @(negedge clock);
        check_value("slow_trip_high after return", slow_trip_high, 1'b0);
        check_value("fault held", fault, 1'b1);
        write_reg(ADDR_CONTROL, control_word(2'b00, 2'b00, 0, FAULT_DELAY, 1'b1, 1'b0, 1));
        @(negedge clock);
        check_value("fault after clear_fault", fault, 1'b0);
        // Three cycles of trip are shorter than the delay
        send_sample(2'd0, 16'sd2500);
        repeat (2) @(negedge clock);
        send_sample(2'd0, 16'sd0);
        repeat (20) @(negedge clock);
        check_value("fault after short excursion", fault, 1'b0);
        write_reg(ADDR_CONTROL, control_word(2'b00, 2'b00, 0, FAULT_DELAY, 1'b0, 1'b1, 1));
        @(negedge clock);
        send_sample(2'd3, -16'sd2500);
        repeat (20) @(negedge clock);
        check_value("slow_trip_low with fault disabled", slow_trip_low, 1'b1);
        check_value("fault while disabled", fault, 1'b0);
        send_sample(2'd3, 16'sd0);
        repeat (3) @(negedge clock);
        check_value("slow_trip_low after return", slow_trip_low, 1'b0);
    endtask

    initial begin
        clock          = 1'b0;
        arst_n         = 1'b0;
        sample_valid   = 1'b0;
        sample_channel = '0;
        sample_data    = '0;
        reg_write      = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        cycle_count    = 0;
        error_count    = 0;
        rng_state      = 32'd32210;
        exp_fast_high  = 1'b0;
        exp_fast_low   = 1'b0;
        for (int i = 0; i < 4; i++) begin
            cal_off[i] = '0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        test_registers();
        test_calibration();
        test_decimation();
        test_fast_comparator();
        test_slow_fault();
        repeat (2) @(negedge clock);
        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

`default_nettype wire

//--- verilog/adc_calibration.sv
/*
 * Offset and gain calibration of the multiplexed sample stream.
 * Adds the channel offset with saturation, then shifts right by cal_shift.
 */
`timescale 1ns/1ps
`default_nettype none

module adc_calibration #(
    parameter int N_CHANNELS = 4
) (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        sample_valid,
    input  wire adc_proc_pkg::channel_t sample_channel,
    input  wire adc_proc_pkg::sample_t sample_data,
    input  wire adc_proc_pkg::sample_t cal_offset [N_CHANNELS],
    input  wire adc_proc_pkg::shift_t  cal_shift,
    output logic                       fast_valid,
    output adc_proc_pkg::channel_t     fast_channel,
    output adc_proc_pkg::sample_t      fast_data
);

    import adc_proc_pkg::*;

    sample_t            offset_sel;
    logic signed [16:0] sum;
    sample_t            sum_sat;

    // Offset lookup; a tag outside the configured channels gets no offset
    always_comb begin
        offset_sel = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (sample_channel == i[1:0]) begin
                offset_sel = cal_offset[i];
            end
        end
    end

    // One guard bit is enough to detect overflow of a 16-bit addition
    assign sum = sample_data + offset_sel;

    always_comb begin
        if (sum > 17'sd32767) begin
            sum_sat = 16'sh7FFF;
        end else if (sum < -17'sd32768) begin
            sum_sat = 16'sh8000;
        end else begin
            sum_sat = sum[15:0];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fast_valid <= 1'b0;
        end else begin
            fast_valid <= sample_valid;
        end
    end

    // Payload follows the strobe; the shift keeps the sign
    always_ff @(posedge clock) begin
        if (sample_valid) begin
            fast_channel <= sample_channel;
            fast_data    <= sum_sat >>> cal_shift;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        sample_valid |-> int'(sample_channel) < N_CHANNELS);

endmodule

`default_nettype wire

//--- verilog/adc_control_regs.sv
/*
 * Register file of the ADC post-processing block.
 * Holds thresholds, per-channel offsets and the control word, produces the
 * clear pulses and runs the fault-delay counter on the slow comparator trips.
 */
`timescale 1ns/1ps
`default_nettype none

module adc_control_regs #(
    parameter int N_CHANNELS   = 4,
    parameter int STICKY_FAULT = 1
) (
    input  wire                       clock,
    input  wire                       arst_n,
    input  wire                       reg_write,
    input  wire adc_proc_pkg::reg_addr_t reg_addr,
    input  wire adc_proc_pkg::reg_data_t reg_wdata,
    output adc_proc_pkg::reg_data_t   reg_rdata,
    input  wire                       slow_trip_high,
    input  wire                       slow_trip_low,
    output adc_proc_pkg::sample_t     fast_thresholds [4],
    output adc_proc_pkg::sample_t     slow_thresholds [4],
    output logic [1:0]                latch_mode,
    output logic [1:0]                clear_latch,
    output adc_proc_pkg::sample_t     cal_offset [N_CHANNELS],
    output adc_proc_pkg::shift_t      cal_shift,
    output adc_proc_pkg::ratio_t      decimation,
    output logic                      fault
);

    import adc_proc_pkg::*;

    // Writable bits of the control word; clear bits and spares read as zero
    localparam reg_data_t CONTROL_MASK = 32'hFF02_FFE6;

    reg_data_t thr_q [4];
    reg_data_t coeff_q;
    reg_data_t control_q;
    logic      clear_fault;
    delay_t    fault_count;
    delay_t    fault_delay;
    logic      fault_disable;
    logic      trip_any;

    // Threshold word order is low_f, low_r, high_f, high_r
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fast_thresholds[i] = thr_q[i][15:0];
            slow_thresholds[i] = thr_q[i][31:16];
        end
    end

    assign latch_mode    = control_q[2:1];
    assign cal_shift     = control_q[7:5];
    assign fault_delay   = control_q[15:8];
    assign fault_disable = control_q[17];
    assign decimation    = control_q[31:24];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                thr_q[i] <= '0;
            end
            for (int i = 0; i < N_CHANNELS; i++) begin
                cal_offset[i] <= '0;
            end
            coeff_q     <= '0;
            control_q   <= '0;
            clear_latch <= '0;
            clear_fault <= 1'b0;
        end else begin
            // Clear strobes last exactly one cycle after the control write
            clear_latch <= '0;
            clear_fault <= 1'b0;
            if (reg_write) begin
                case (reg_addr)
                    ADDR_CMP_LOW_F:  thr_q[0] <= reg_wdata;
                    ADDR_CMP_LOW_R:  thr_q[1] <= reg_wdata;
                    ADDR_CMP_HIGH_F: thr_q[2] <= reg_wdata;
                    ADDR_CMP_HIGH_R: thr_q[3] <= reg_wdata;
                    ADDR_CAL_COEFF: begin
                        coeff_q <= {reg_wdata[31:16], 14'd0, reg_wdata[1:0]};
                        // Only the addressed channel takes the new offset
                        for (int i = 0; i < N_CHANNELS; i++) begin
                            if (reg_wdata[1:0] == i[1:0]) begin
                                cal_offset[i] <= reg_wdata[31:16];
                            end
                        end
                    end
                    ADDR_CONTROL: begin
                        control_q   <= reg_wdata & CONTROL_MASK;
                        clear_latch <= reg_wdata[4:3];
                        clear_fault <= reg_wdata[16];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read port is combinational and unknown offsets read zero
    always_comb begin
        case (reg_addr)
            ADDR_CMP_LOW_F:  reg_rdata = thr_q[0];
            ADDR_CMP_LOW_R:  reg_rdata = thr_q[1];
            ADDR_CMP_HIGH_F: reg_rdata = thr_q[2];
            ADDR_CMP_HIGH_R: reg_rdata = thr_q[3];
            ADDR_CAL_COEFF:  reg_rdata = coeff_q;
            ADDR_CONTROL:    reg_rdata = control_q;
            default:         reg_rdata = '0;
        endcase
    end

    assign trip_any = slow_trip_high | slow_trip_low;

    // The counter runs while a slow trip stays active and restarts when both drop
    // Fault is raised on the edge where the count has reached fault_delay
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fault_count <= '0;
            fault       <= 1'b0;
        end else begin
            if (!trip_any) begin
                fault_count <= '0;
            end else if (fault_count != fault_delay) begin
                fault_count <= fault_count + 8'd1;
            end
            if (trip_any && fault_count == fault_delay && !fault_disable) begin
                fault <= 1'b1;
            end else if (STICKY_FAULT != 0) begin
                // Sticky fault waits for an explicit clear
                if (clear_fault) begin
                    fault <= 1'b0;
                end
            end else begin
                fault <= 1'b0;
            end
        end
    end

    // A disabled fault path must never produce a rising fault
    assert property (@(posedge clock) disable iff (!arst_n)
        $rose(fault) |-> !$past(fault_disable));

endmodule

`default_nettype wire

//--- verilog/adc_proc_pkg.sv
/*
 * Shared types and register map of the ADC post-processing block.
 * Every data-path module and the register file import from here.
 */
`default_nettype none

package adc_proc_pkg;

    // One ADC sample or calibrated result, always signed
    typedef logic signed [15:0] sample_t;

    // Channel tag of a multiplexed sample, up to four channels
    typedef logic [1:0] channel_t;

    // Register bus types
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Configuration field types
    typedef logic [2:0] shift_t;
    typedef logic [7:0] ratio_t;
    typedef logic [7:0] delay_t;

    // Byte offsets of the registers
    localparam reg_addr_t ADDR_CMP_LOW_F  = 5'h00;
    localparam reg_addr_t ADDR_CMP_LOW_R  = 5'h04;
    localparam reg_addr_t ADDR_CMP_HIGH_F = 5'h08;
    localparam reg_addr_t ADDR_CMP_HIGH_R = 5'h0C;
    localparam reg_addr_t ADDR_CAL_COEFF  = 5'h10;
    localparam reg_addr_t ADDR_CONTROL    = 5'h14;

endpackage

`default_nettype wire

//--- verilog/adc_processing.sv
/*
 * Top level of the ADC post-processing block.
 * Samples pass through calibration to the fast output and through the
 * decimator to the filtered output; fast and slow comparators watch both.
 */
`timescale 1ns/1ps
`default_nettype none

module adc_processing #(
    parameter int N_CHANNELS   = 4,
    parameter int STICKY_FAULT = 1
) (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        sample_valid,
    input  wire adc_proc_pkg::channel_t sample_channel,
    input  wire adc_proc_pkg::sample_t sample_data,
    input  wire                        reg_write,
    input  wire adc_proc_pkg::reg_addr_t reg_addr,
    input  wire adc_proc_pkg::reg_data_t reg_wdata,
    output adc_proc_pkg::reg_data_t    reg_rdata,
    output logic                       fast_valid,
    output adc_proc_pkg::channel_t     fast_channel,
    output adc_proc_pkg::sample_t      fast_data,
    output logic                       filtered_valid,
    output adc_proc_pkg::channel_t     filtered_channel,
    output adc_proc_pkg::sample_t      filtered_data,
    output logic                       fast_trip_high,
    output logic                       fast_trip_low,
    output logic                       slow_trip_high,
    output logic                       slow_trip_low,
    output logic                       fault
);

    import adc_proc_pkg::*;

    sample_t    fast_thresholds [4];
    sample_t    slow_thresholds [4];
    sample_t    cal_offset [N_CHANNELS];
    shift_t     cal_shift;
    ratio_t     decimation;
    logic [1:0] latch_mode;
    logic [1:0] clear_latch;

    adc_control_regs #(
        .N_CHANNELS(N_CHANNELS),
        .STICKY_FAULT(STICKY_FAULT)
    ) i_control (
        .clock(clock),
        .arst_n(arst_n),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .slow_trip_high(slow_trip_high),
        .slow_trip_low(slow_trip_low),
        .fast_thresholds(fast_thresholds),
        .slow_thresholds(slow_thresholds),
        .latch_mode(latch_mode),
        .clear_latch(clear_latch),
        .cal_offset(cal_offset),
        .cal_shift(cal_shift),
        .decimation(decimation),
        .fault(fault)
    );

    adc_calibration #(
        .N_CHANNELS(N_CHANNELS)
    ) i_calibration (
        .clock(clock),
        .arst_n(arst_n),
        .sample_valid(sample_valid),
        .sample_channel(sample_channel),
        .sample_data(sample_data),
        .cal_offset(cal_offset),
        .cal_shift(cal_shift),
        .fast_valid(fast_valid),
        .fast_channel(fast_channel),
        .fast_data(fast_data)
    );

    sample_decimator #(
        .N_CHANNELS(N_CHANNELS)
    ) i_decimator (
        .clock(clock),
        .arst_n(arst_n),
        .in_valid(fast_valid),
        .in_channel(fast_channel),
        .in_data(fast_data),
        .decimation(decimation),
        .out_valid(filtered_valid),
        .out_channel(filtered_channel),
        .out_data(filtered_data)
    );

    // Bit 0 of latch_mode and clear_latch belongs to the fast comparator
    threshold_comparator #(
        .N_CHANNELS(N_CHANNELS)
    ) fast_cmp (
        .clock(clock),
        .arst_n(arst_n),
        .in_valid(fast_valid),
        .in_channel(fast_channel),
        .in_data(fast_data),
        .thresholds(fast_thresholds),
        .latching_mode(latch_mode[0]),
        .clear_latch(clear_latch[0]),
        .trip_high(fast_trip_high),
        .trip_low(fast_trip_low)
    );

    threshold_comparator #(
        .N_CHANNELS(N_CHANNELS)
    ) slow_cmp (
        .clock(clock),
        .arst_n(arst_n),
        .in_valid(filtered_valid),
        .in_channel(filtered_channel),
        .in_data(filtered_data),
        .thresholds(slow_thresholds),
        .latching_mode(latch_mode[1]),
        .clear_latch(clear_latch[1]),
        .trip_high(slow_trip_high),
        .trip_low(slow_trip_low)
    );

endmodule

`default_nettype wire

//--- verilog/sample_decimator.sv
/*
 * Per-channel decimator of the calibrated stream.
 * Forwards the first sample of each channel and then every Nth one.
 */
`timescale 1ns/1ps
`default_nettype none

module sample_decimator #(
    parameter int N_CHANNELS = 4
) (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        in_valid,
    input  wire adc_proc_pkg::channel_t in_channel,
    input  wire adc_proc_pkg::sample_t in_data,
    input  wire adc_proc_pkg::ratio_t  decimation,
    output logic                       out_valid,
    output adc_proc_pkg::channel_t     out_channel,
    output adc_proc_pkg::sample_t      out_data
);

    import adc_proc_pkg::*;

    ratio_t count [N_CHANNELS];
    ratio_t ratio;

    // A ratio of zero behaves as one, so every sample passes
    assign ratio = (decimation == '0) ? 8'd1 : decimation;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                count[i] <= '0;
            end
        end else begin
            out_valid <= 1'b0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                // Only the channel of the current sample advances
                if (in_valid && in_channel == i[1:0]) begin
                    out_valid <= (count[i] == '0);
                    // Wraps early too if the ratio shrank below the count
                    if (count[i] >= ratio - 8'd1) begin
                        count[i] <= '0;
                    end else begin
                        count[i] <= count[i] + 8'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_channel <= in_channel;
            out_data    <= in_data;
        end
    end

    // Nothing leaves the decimator without a sample on the previous cycle
    assert property (@(posedge clock) disable iff (!arst_n)
        !in_valid |=> !out_valid);

endmodule

`default_nettype wire

//--- verilog/threshold_comparator.sv
/*
 * Window comparator with hysteresis on a multiplexed sample stream.
 * Tracks a high and a low state per channel and reports their OR.
 * In latching mode the states stay set until clear_latch.
 */
`timescale 1ns/1ps
`default_nettype none

module threshold_comparator #(
    parameter int N_CHANNELS = 4
) (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        in_valid,
    input  wire adc_proc_pkg::channel_t in_channel,
    input  wire adc_proc_pkg::sample_t in_data,
    input  wire adc_proc_pkg::sample_t thresholds [4],
    input  wire                        latching_mode,
    input  wire                        clear_latch,
    output logic                       trip_high,
    output logic                       trip_low
);

    import adc_proc_pkg::*;

    logic [N_CHANNELS-1:0] high_state;
    logic [N_CHANNELS-1:0] low_state;
    sample_t               low_f;
    sample_t               low_r;
    sample_t               high_f;
    sample_t               high_r;

    assign low_f  = thresholds[0];
    assign low_r  = thresholds[1];
    assign high_f = thresholds[2];
    assign high_r = thresholds[3];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            high_state <= '0;
            low_state  <= '0;
        end else begin
            // Clearing drops every channel, a sample on the same edge may set again
            if (clear_latch) begin
                high_state <= '0;
                low_state  <= '0;
            end
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (in_valid && in_channel == i[1:0]) begin
                    // Setting conditions apply in both modes
                    if (in_data > high_r) begin
                        high_state[i] <= 1'b1;
                    end else if (!latching_mode && in_data < high_f) begin
                        high_state[i] <= 1'b0;
                    end
                    if (in_data < low_f) begin
                        low_state[i] <= 1'b1;
                    end else if (!latching_mode && in_data > low_r) begin
                        low_state[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Any channel out of window trips the output
    assign trip_high = |high_state;
    assign trip_low  = |low_state;

endmodule

`default_nettype wire
